//--- source/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and storage sizes
`define WORD_W      16
`define REG_CNT     8
`define REG_W       3
`define IMEM_DEPTH  64
`define IMEM_AW     6
`define DMEM_DEPTH  32
`define DMEM_AW     5

// Opcodes live in instr[15:11]
`define OP_HALT     5'b00000
`define OP_NOP      5'b00001
`define OP_J        5'b00100
`define OP_ADDI     5'b01000
`define OP_BEQZ     5'b01100
`define OP_ST       5'b10000
`define OP_LD       5'b10001
`define OP_ADD      5'b11000
`define OP_SUB      5'b11001

`endif

//--- source/cpuPkg.sv
`default_nettype none
`include "cpu_consts.svh"

package cpuPkg;

    // Three-register layout, ADD and SUB
    typedef struct packed {
        logic [4:0]        opcode;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] rd;
        logic [1:0]        spare;
    } rFormFields;

    // Immediate layout, also carries the J target in its low 11 bits
    typedef struct packed {
        logic [4:0]        opcode;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [4:0]        imm;
    } iFormFields;

    typedef union packed {
        rFormFields rForm;
        iFormFields iForm;
    } instrWord;

    typedef enum logic [1:0] {
        fwdRf    = 2'd0, // Value read in decode
        fwdExMem = 2'd1,
        fwdMemWb = 2'd2
    } fwdSel;

    typedef struct packed {
        logic                valid;
        logic [`WORD_W-1:0]  pc;
        instrWord            instr;
    } ifIdReg;

    typedef struct packed {
        logic                valid;
        logic [4:0]          opcode;
        logic [`REG_W-1:0]   rd;
        logic                regWrite;
        logic [`REG_W-1:0]   rs;
        logic [`REG_W-1:0]   rt;
        logic [`WORD_W-1:0]  opA;
        logic [`WORD_W-1:0]  opB;
        logic [`WORD_W-1:0]  imm;      // Branch target for BEQZ
        logic                memRead;
        logic                memWrite;
        fwdSel               fwdA;
        fwdSel               fwdB;
    } idExReg;

    typedef struct packed {
        logic                valid;
        logic [`REG_W-1:0]   rd;
        logic                regWrite;
        logic [`WORD_W-1:0]  result;   // ALU value or memory address
        logic [`WORD_W-1:0]  storeData;
        logic                memRead;
        logic                memWrite;
    } exMemReg;

    typedef struct packed {
        logic                valid;
        logic [`REG_W-1:0]   rd;
        logic                regWrite;
        logic [`WORD_W-1:0]  result;
    } memWbReg;

endpackage

`default_nettype wire

//--- source/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module fetchStage (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire                      run,
    input  wire                      progWrite,
    input  wire [`IMEM_AW-1:0]       progAddr,
    input  wire [`WORD_W-1:0]        progData,
    input  wire                      stall,
    input  wire                      squash,
    input  wire                      redirect,
    input  wire [`WORD_W-1:0]        redirectPc,
    output cpuPkg::ifIdReg           ifId
);

    logic [`WORD_W-1:0] imem [`IMEM_DEPTH];
    logic [`WORD_W-1:0] pc;
    cpuPkg::instrWord   fetched;

    assign fetched = imem[pc[`IMEM_AW-1:0]]; // PC wraps on the low bits

    // Program load port, only while the core is held
    always_ff @(posedge clk) begin
        if (progWrite && !run) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            pc <= '0; // Next run starts at address 0
        end else if (redirect) begin
            pc <= redirectPc; // Taken branch or jump wins over a stall
        end else if (!stall) begin
            pc <= pc + `WORD_W'(1);
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ifId.valid <= 1'b0;
        end else if (!run || squash) begin
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId.valid <= 1'b1;
            ifId.pc    <= pc;
            ifId.instr <= fetched;
        end
    end

endmodule

`default_nettype wire

//--- source/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module decodeStage (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire cpuPkg::ifIdReg      ifId,
    input  wire                      stall,
    input  wire                      bubble,
    input  wire                      squash,
    input  wire cpuPkg::fwdSel       fwdA,
    input  wire cpuPkg::fwdSel       fwdB,
    input  wire cpuPkg::memWbReg     memWb,
    output cpuPkg::idExReg           idEx,
    output logic                     jumpTaken,
    output logic [`WORD_W-1:0]       jumpPc,
    output logic                     halted
);

    logic [`WORD_W-1:0] regFile [`REG_CNT];
    cpuPkg::instrWord   instr;
    logic [4:0]         opcode;
    logic [`WORD_W-1:0] immExt;
    logic [1:0]         haltPipe;  // HALT walking through execute and memory
    logic               stopped;
    logic               haltDecoded;
    cpuPkg::idExReg     idExNext;

    function automatic logic [`WORD_W-1:0] readReg(input logic [`REG_W-1:0] r);
        if (r == '0) begin
            return '0;
        end
        if (memWb.valid && memWb.regWrite && memWb.rd == r) begin
            return memWb.result; // Write in the same cycle
        end
        return regFile[r];
    endfunction

    assign instr       = ifId.instr;
    assign opcode      = instr.rForm.opcode;
    assign immExt      = {{(`WORD_W-5){instr.iForm.imm[4]}}, instr.iForm.imm};
    assign stopped     = halted | (|haltPipe);
    assign haltDecoded = ifId.valid & ~stopped & ~stall & ~squash & (opcode == `OP_HALT);

    // J resolves here, absolute 11-bit target
    assign jumpTaken = ifId.valid & ~stopped & (opcode == `OP_J);
    assign jumpPc    = {{(`WORD_W-11){1'b0}}, instr.iForm.rs, instr.iForm.rt, instr.iForm.imm};

    always_comb begin
        idExNext          = '0;
        // A jump squash only clears IF/ID, the J itself moves on
        idExNext.valid    = ifId.valid & ~stopped & ~bubble & ~(squash & ~jumpTaken);
        idExNext.opcode   = opcode;
        idExNext.rs       = instr.rForm.rs;
        idExNext.rt       = instr.rForm.rt;
        idExNext.opA      = readReg(instr.rForm.rs);
        idExNext.opB      = readReg(instr.rForm.rt);
        idExNext.imm      = immExt;
        idExNext.fwdA     = fwdA;
        idExNext.fwdB     = fwdB;
        case (opcode)
            `OP_ADD, `OP_SUB: begin
                idExNext.rd       = instr.rForm.rd;
                idExNext.regWrite = 1'b1;
            end
            `OP_ADDI: begin
                idExNext.rd       = instr.iForm.rt;
                idExNext.regWrite = 1'b1;
            end
            `OP_LD: begin
                idExNext.rd       = instr.iForm.rt;
                idExNext.regWrite = 1'b1;
                idExNext.memRead  = 1'b1;
            end
            `OP_ST:   idExNext.memWrite = 1'b1;
            `OP_BEQZ: idExNext.imm = ifId.pc + `WORD_W'(1) + immExt; // Target, pc relative
            default: ;
        endcase
        if (idExNext.rd == '0) begin
            idExNext.regWrite = 1'b0; // R0 is never written
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (memWb.valid && memWb.regWrite && memWb.rd != '0) begin
            regFile[memWb.rd] <= memWb.result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx <= idExNext;
        end
    end

    // Halted rises as HALT sits in MEM/WB
    always_ff @(posedge clk) begin
        if (!rstN) begin
            haltPipe <= '0;
            halted   <= 1'b0;
        end else begin
            haltPipe <= {haltPipe[0], haltDecoded};
            halted   <= halted | haltPipe[1];
        end
    end

endmodule

`default_nettype wire

//--- source/hazardDetect.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module hazardDetect (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire cpuPkg::instrWord    instr,
    input  wire                      instrValid,
    input  wire cpuPkg::idExReg      idEx,
    input  wire cpuPkg::exMemReg     exMem,
    input  wire cpuPkg::memWbReg     memWb,
    input  wire                      branchTaken,
    input  wire                      jumpTaken,
    output logic                     stall,
    output logic                     bubble,
    output logic                     squash,
    output cpuPkg::fwdSel            fwdA,
    output cpuPkg::fwdSel            fwdB
);

    logic [4:0]        opcode;
    logic [`REG_W-1:0] srcA;
    logic [`REG_W-1:0] srcB;
    logic              useA;
    logic              useB;
    logic              loadUse;
    logic              jumpHeld;

    // Chooses where the source comes from one cycle later, in execute
    // A write now in MEM/WB reaches decode through the register file bypass
    function automatic cpuPkg::fwdSel pickSource(input logic needed,
                                                 input logic [`REG_W-1:0] src);
        if (!needed || src == '0) begin
            return cpuPkg::fwdRf;
        end
        // Youngest writer first
        if (idEx.valid && idEx.regWrite && idEx.rd == src) begin
            return cpuPkg::fwdExMem;
        end
        if (exMem.valid && exMem.regWrite && exMem.rd == src) begin
            return cpuPkg::fwdMemWb;
        end
        return cpuPkg::fwdRf;
    endfunction

    assign opcode = instr.rForm.opcode;
    assign srcA   = instr.rForm.rs;
    assign srcB   = instr.rForm.rt;

    // Which fields are real sources for this opcode
    always_comb begin
        useA = 1'b0;
        useB = 1'b0;
        case (opcode)
            `OP_ADD, `OP_SUB, `OP_ST: begin
                useA = 1'b1;
                useB = 1'b1; // ST data comes from rt
            end
            `OP_ADDI, `OP_LD, `OP_BEQZ: useA = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        fwdA = pickSource(useA, srcA);
        fwdB = pickSource(useB, srcB);
    end

    // Load data is not ready until MEM/WB
    assign loadUse = instrValid && idEx.valid && idEx.memRead && idEx.regWrite &&
                     ((useA && srcA == idEx.rd) || (useB && srcB == idEx.rd));

    assign stall  = loadUse;
    assign bubble = loadUse;

    // A jump held in decode has already squashed once
    always_ff @(posedge clk) begin
        if (!rstN) begin
            jumpHeld <= 1'b0;
        end else begin
            jumpHeld <= jumpTaken && stall;
        end
    end

    assign squash = branchTaken || (jumpTaken && !jumpHeld);

endmodule

`default_nettype wire

//--- source/executeStage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module executeStage (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire cpuPkg::idExReg      idEx,
    input  wire cpuPkg::exMemReg     exMemFwd,
    input  wire cpuPkg::memWbReg     memWbFwd,
    output cpuPkg::exMemReg          exMem,
    output logic                     branchTaken,
    output logic [`WORD_W-1:0]       branchPc
);

    logic [`WORD_W-1:0] opA;
    logic [`WORD_W-1:0] opB;
    logic [`WORD_W-1:0] aluOut;
    cpuPkg::exMemReg    exMemNext;

    function automatic logic [`WORD_W-1:0] pickOperand(input cpuPkg::fwdSel sel,
                                                       input logic [`WORD_W-1:0] regVal);
        case (sel)
            cpuPkg::fwdExMem: return exMemFwd.result;
            cpuPkg::fwdMemWb: return memWbFwd.result;
            default:          return regVal;
        endcase
    endfunction

    always_comb begin
        opA = pickOperand(idEx.fwdA, idEx.opA);
        opB = pickOperand(idEx.fwdB, idEx.opB);
    end

    always_comb begin
        case (idEx.opcode)
            `OP_ADD:                  aluOut = opA + opB;
            `OP_SUB:                  aluOut = opA - opB;
            `OP_ADDI, `OP_LD, `OP_ST: aluOut = opA + idEx.imm; // LD/ST address too
            default:                  aluOut = '0;
        endcase
    end

    // BEQZ tests the forwarded rs
    assign branchTaken = idEx.valid && idEx.opcode == `OP_BEQZ && opA == '0;
    assign branchPc    = idEx.imm;

    always_comb begin
        exMemNext           = '0;
        exMemNext.valid     = idEx.valid;
        exMemNext.rd        = idEx.rd;
        exMemNext.regWrite  = idEx.regWrite;
        exMemNext.result    = aluOut;
        exMemNext.storeData = opB;
        exMemNext.memRead   = idEx.memRead;
        exMemNext.memWrite  = idEx.memWrite;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem <= exMemNext;
        end
    end

endmodule

`default_nettype wire

//--- source/memoryStage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module memoryStage (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire cpuPkg::exMemReg     exMem,
    output cpuPkg::memWbReg          memWb,
    output logic                     wbValid,
    output logic [`REG_W-1:0]        wbReg,
    output logic [`WORD_W-1:0]       wbData
);

    logic [`WORD_W-1:0]  dmem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0] addr;
    logic [`WORD_W-1:0]  loadData;

    assign addr     = exMem.result[`DMEM_AW-1:0]; // Upper address bits ignored
    assign loadData = dmem[addr];

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.memWrite) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWb.valid <= 1'b0;
        end else begin
            memWb.valid    <= exMem.valid;
            memWb.rd       <= exMem.rd;
            memWb.regWrite <= exMem.regWrite;
            memWb.result   <= exMem.memRead ? loadData : exMem.result;
        end
    end

    // Writeback report, one strobe per register write
    assign wbValid = memWb.valid && memWb.regWrite && memWb.rd != '0;
    assign wbReg   = memWb.rd;
    assign wbData  = memWb.result;

endmodule

`default_nettype wire

//--- source/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpuTop (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire                      run,
    input  wire                      progWrite,
    input  wire [`IMEM_AW-1:0]       progAddr,
    input  wire [`WORD_W-1:0]        progData,
    output logic                     wbValid,
    output logic [`REG_W-1:0]        wbReg,
    output logic [`WORD_W-1:0]       wbData,
    output logic                     halted
);

    cpuPkg::ifIdReg     ifId;
    cpuPkg::idExReg     idEx;
    cpuPkg::exMemReg    exMem;
    cpuPkg::memWbReg    memWb;
    cpuPkg::fwdSel      fwdA;
    cpuPkg::fwdSel      fwdB;
    logic               stall;
    logic               bubble;
    logic               squash;
    logic               branchTaken;
    logic               jumpTaken;
    logic               redirect;
    logic [`WORD_W-1:0] branchPc;
    logic [`WORD_W-1:0] jumpPc;
    logic [`WORD_W-1:0] redirectPc;

    // The older branch wins over a jump in decode
    assign redirect   = branchTaken | jumpTaken;
    assign redirectPc = branchTaken ? branchPc : jumpPc;

    fetchStage uFetch (
        .clk(clk), .rstN(rstN), .run(run),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .stall(stall), .squash(squash),
        .redirect(redirect), .redirectPc(redirectPc),
        .ifId(ifId)
    );

    decodeStage uDecode (
        .clk(clk), .rstN(rstN), .ifId(ifId),
        .stall(stall), .bubble(bubble), .squash(squash),
        .fwdA(fwdA), .fwdB(fwdB), .memWb(memWb),
        .idEx(idEx), .jumpTaken(jumpTaken), .jumpPc(jumpPc), .halted(halted)
    );

    hazardDetect uHazard (
        .clk(clk), .rstN(rstN),
        .instr(ifId.instr), .instrValid(ifId.valid),
        .idEx(idEx), .exMem(exMem), .memWb(memWb),
        .branchTaken(branchTaken), .jumpTaken(jumpTaken),
        .stall(stall), .bubble(bubble), .squash(squash),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    executeStage uExecute (
        .clk(clk), .rstN(rstN), .idEx(idEx),
        .exMemFwd(exMem), .memWbFwd(memWb),
        .exMem(exMem), .branchTaken(branchTaken), .branchPc(branchPc)
    );

    memoryStage uMemory (
        .clk(clk), .rstN(rstN), .exMem(exMem), .memWb(memWb),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod = 2 // 4 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(halfPeriod) clk = ~clk;

endmodule

`default_nettype wire

//--- tests/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpuTb;

    logic                clk;
    logic                rstN;
    logic                run;
    logic                progWrite;
    logic [`IMEM_AW-1:0] progAddr;
    logic [`WORD_W-1:0]  progData;
    logic                wbValid;
    logic [`REG_W-1:0]   wbReg;
    logic [`WORD_W-1:0]  wbData;
    logic                halted;

    logic [`WORD_W-1:0]  prog [`IMEM_DEPTH];
    int                  progLen;
    logic [`WORD_W-1:0]  modelReg [`REG_CNT];
    logic [`WORD_W-1:0]  modelMem [`DMEM_DEPTH]; // Kept across runs like the DUT memory
    logic [`REG_W-1:0]   expReg [$];
    logic [`WORD_W-1:0]  expData [$];
    logic [16:0]         lfsrState = 17'd73990;
    string               testName = "idle";
    int                  valueErrors = 0;
    int                  flowErrors = 0;

    clockGen clkSrc (.clk(clk));

    cpuTop dut_i (
        .clk(clk), .rstN(rstN), .run(run),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
    );

    // 17-bit Fibonacci LFSR, taps 17 and 14
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[16] ^ lfsrState[13];
            lfsrState = {lfsrState[15:0], fb};
            val       = {val[14:0], fb};
        end
        return val;
    endfunction

    function automatic logic [15:0] rInstr(input logic [4:0] op, input int rs, rt, rd);
        return {op, rs[2:0], rt[2:0], rd[2:0], 2'b00};
    endfunction

    function automatic logic [15:0] iInstr(input logic [4:0] op, input int rs, rt, imm);
        return {op, rs[2:0], rt[2:0], imm[4:0]};
    endfunction

    function automatic logic [15:0] jInstr(input int target);
        return {`OP_J, target[10:0]};
    endfunction

    function automatic logic [15:0] randomInstr();
        int kind;
        int rs;
        int rt;
        int rdOrImm;
        kind    = randBits(3) % 5;
        rs      = randBits(3);
        rt      = randBits(3);
        rdOrImm = randBits(5);
        case (kind)
            0:       return rInstr(`OP_ADD, rs, rt, rdOrImm);
            1:       return rInstr(`OP_SUB, rs, rt, rdOrImm);
            2:       return iInstr(`OP_ADDI, rs, rt, rdOrImm);
            3:       return iInstr(`OP_LD, rs, rt, rdOrImm);
            default: return iInstr(`OP_ST, rs, rt, rdOrImm);
        endcase
    endfunction

    task automatic appendInstr(input logic [15:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // ISA reference, one instruction per step
    task automatic runModel();
        int          pc;
        int          steps;
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] ea;
        logic [15:0] res;
        logic [2:0]  dst;
        logic        writes;
        logic        done;
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        for (int r = 0; r < `REG_CNT; r++) begin
            modelReg[r] = '0;
        end
        while (!done && steps < 256) begin
            w      = prog[pc % `IMEM_DEPTH];
            a      = modelReg[w[10:8]];
            b      = modelReg[w[7:5]];
            imm    = {{11{w[4]}}, w[4:0]};
            ea     = a + imm;
            dst    = w[7:5];
            writes = 1'b0;
            pc     = pc + 1;
            steps++;
            case (w[15:11])
                `OP_ADD, `OP_SUB: begin
                    res    = (w[15:11] == `OP_ADD) ? a + b : a - b;
                    dst    = w[4:2];
                    writes = 1'b1;
                end
                `OP_ADDI: begin
                    res    = ea;
                    writes = 1'b1;
                end
                `OP_LD: begin
                    res    = modelMem[ea[`DMEM_AW-1:0]];
                    writes = 1'b1;
                end
                `OP_ST:   modelMem[ea[`DMEM_AW-1:0]] = b;
                `OP_BEQZ: if (a == '0) pc = pc + $signed(w[4:0]);
                `OP_J:    pc = w[10:0];
                `OP_HALT: done = 1'b1;
                default: ;
            endcase
            if (writes && dst != '0) begin
                modelReg[dst] = res;
                expReg.push_back(dst);
                expData.push_back(res);
            end
        end
    endtask

    task automatic resetCore();
        @(negedge clk);
        run  = 1'b0;
        rstN = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        testName = name;
        resetCore();
        for (int i = 0; i < progLen; i++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr  = `IMEM_AW'(i);
            progData  = prog[i];
        end
        @(negedge clk);
        progWrite = 1'b0;
        expReg.delete();
        expData.delete();
        runModel();
        run    = 1'b1;
        cycles = 0;
        while (!halted && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        assert (halted) else begin
            flowErrors++;
            $display("%s: halted did not rise within %0d cycles", name, cycles);
        end
        repeat (4) @(negedge clk); // Catches a late extra writeback
        assert (expReg.size() == 0) else begin
            flowErrors++;
            $display("%s: %0d expected writebacks never appeared", name, expReg.size());
        end
        run = 1'b0;
    endtask

    // Each strobe is matched against the next pair from the model
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            assert (expReg.size() > 0) else begin
                flowErrors++;
                $display("%s: writeback to r%0d that the model never made", testName, wbReg);
            end
            if (expReg.size() > 0) begin
                assert (wbReg == expReg[0]) else begin
                    valueErrors++;
                    $display("[FAIL] %s: register expected r%0d, actual r%0d",
                             testName, expReg[0], wbReg);
                end
                assert (wbData == expData[0]) else begin
                    valueErrors++;
                    $display("[FAIL] %s: r%0d data expected %h, actual %h",
                             testName, expReg[0], expData[0], wbData);
                end
                void'(expReg.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    initial begin
        rstN      = 1'b0;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;

        testName = "idleBeforeRun";
        resetCore();
        repeat (10) begin
            @(negedge clk);
            assert (!wbValid && !halted) else begin
                valueErrors++;
                $display("[FAIL] %s: wbValid/halted expected 0/0, actual %b/%b",
                         testName, wbValid, halted);
            end
        end

        // Zero every data word, imm -16..15 covers all 32 addresses
        progLen = 0;
        for (int i = -16; i < 16; i++) begin
            appendInstr(iInstr(`OP_ST, 0, 0, i));
        end
        appendInstr(iInstr(`OP_HALT, 0, 0, 0));
        runProgram("clearMemory");

        progLen = 0;
        appendInstr(iInstr(`OP_ADDI, 0, 1, randBits(5)));
        appendInstr(iInstr(`OP_ADDI, 1, 2, randBits(5)));
        appendInstr(rInstr(`OP_ADD, 2, 1, 3)); // r2 from EX/MEM, r1 from MEM/WB
        appendInstr(rInstr(`OP_SUB, 3, 2, 4));
        appendInstr(rInstr(`OP_ADD, 4, 4, 5));
        appendInstr(iInstr(`OP_ADDI, 5, 6, randBits(5)));
        appendInstr(rInstr(`OP_SUB, 6, 1, 7));
        appendInstr(iInstr(`OP_HALT, 0, 0, 0));
        runProgram("aluChain");

        progLen = 0;
        appendInstr(iInstr(`OP_ADDI, 0, 1, 9));
        appendInstr(iInstr(`OP_ADDI, 0, 2, 5));
        appendInstr(iInstr(`OP_ST, 2, 1, 3));
        appendInstr(iInstr(`OP_LD, 2, 3, 3));
        appendInstr(rInstr(`OP_ADD, 3, 1, 4)); // Load-use on r3
        appendInstr(iInstr(`OP_ST, 0, 4, 12));
        appendInstr(iInstr(`OP_LD, 0, 5, 12));
        appendInstr(iInstr(`OP_ADDI, 5, 6, -1));
        appendInstr(iInstr(`OP_HALT, 0, 0, 0));
        runProgram("loadUse");

        progLen = 0;
        appendInstr(iInstr(`OP_ADDI, 0, 1, 4));
        appendInstr(rInstr(`OP_SUB, 1, 1, 2));
        appendInstr(iInstr(`OP_BEQZ, 2, 0, 2)); // Taken, lands on address 5
        appendInstr(iInstr(`OP_ADDI, 0, 3, 1));
        appendInstr(iInstr(`OP_ADDI, 0, 4, 2));
        appendInstr(iInstr(`OP_ADDI, 0, 5, 7));
        appendInstr(iInstr(`OP_BEQZ, 1, 0, 3)); // Not taken
        appendInstr(iInstr(`OP_ADDI, 0, 6, 3));
        appendInstr(iInstr(`OP_ADDI, 0, 7, 5));
        appendInstr(iInstr(`OP_HALT, 0, 0, 0));
        runProgram("branch");

        progLen = 0;
        appendInstr(iInstr(`OP_ADDI, 0, 1, 1));
        appendInstr(jInstr(3));
        appendInstr(iInstr(`OP_ADDI, 0, 2, 9));
        appendInstr(iInstr(`OP_ADDI, 1, 0, 5));
        appendInstr(rInstr(`OP_ADD, 1, 1, 0));
        appendInstr(rInstr(`OP_ADD, 0, 1, 3)); // r0 still reads zero
        appendInstr(iInstr(`OP_HALT, 0, 0, 0));
        runProgram("jumpAndR0");

        progLen = 0;
        for (int i = 0; i < 40; i++) begin
            appendInstr(randomInstr());
        end
        appendInstr(iInstr(`OP_HALT, 0, 0, 0));
        runProgram("randomProgram");

        $display("Writeback checks finished: %0d wrong values, %0d flow errors",
                 valueErrors, flowErrors);
        if (valueErrors + flowErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/cpuPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardDetect.sv
source/executeStage.sv
source/memoryStage.sv
source/cpuTop.sv
tests/clockGen.sv
tests/cpuTb.sv
